//--- sources.f
rtl/rv32i_types.sv
rtl/stall_if.sv
rtl/stall_fsm.sv
rtl/stall_counter.sv
rtl/fetch_unit.sv
rtl/mem_stage.sv
rtl/mem_stall_top.sv
sim/mem_responder.sv
sim/tb_mem_stall.sv

//--- sim/tb_mem_stall.sv
// Testbench for the memory-stall front end: program run, retire and stall checks
module tb_mem_stall;

    localparam int          PROG_WORDS = 64;
    localparam int          NUM_RETIRE = 48;
    localparam int          MAX_GAP    = 50; // Cycles allowed between retirements
    localparam logic [31:0] NOP_WORD   = 32'h0000_0013;

    typedef struct packed {
        logic [rv32i_types::XLEN-1:0] pc;
        rv32i_types::mem_op           op;
        logic [rv32i_types::XLEN-1:0] addr;
        logic [rv32i_types::XLEN-1:0] word;
        logic [rv32i_types::XLEN-1:0] data;
    } retire_t;

    logic clk = 1'b0;
    logic rst;
    logic imem_req, imem_resp, dmem_req, dmem_we, dmem_resp, retire_valid;
    logic [rv32i_types::XLEN-1:0] imem_addr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
    logic [rv32i_types::XLEN-1:0] retire_pc, retire_data;
    rv32i_types::mem_op retire_op;
    logic [rv32i_types::STALL_CNT_W-1:0] stall_cycles;

    logic [rv32i_types::XLEN-1:0] prog [0:PROG_WORDS-1];
    logic [rv32i_types::STALL_CNT_W-1:0] stall_seen = '0;
    logic    dmem_seen = 1'b0;
    logic    imem_seen = 1'b0;
    retire_t exp_r;
    int checks = 0;
    int errors = 0;
    int timeouts = 0;
    int retired = 0;
    int fetched = 0;
    int cycles = 0;
    int cycles_seen = 0;

    mem_stall_top dut_i (.*);
    mem_responder resp_i (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (!rst) begin
            cycles <= cycles + 1;
        end
    end

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h0101_0101) ^ 32'hc3a5_5a3c;
    endfunction

    function automatic logic [31:0] lw_word(input logic [11:0] imm);
        return {imm, 5'd0, 3'b010, 5'd5, rv32i_types::OPC_LOAD};
    endfunction

    function automatic logic [31:0] sw_word(input logic [11:0] imm);
        return {imm[11:5], 5'd6, 5'd0, 3'b010, imm[4:0], rv32i_types::OPC_STORE};
    endfunction

    function automatic logic [31:0] addi_word(input logic [11:0] imm);
        return {imm, 5'd0, 3'b000, 5'd1, 7'b0010011};
    endfunction

    // Walks the program in order while stores update a shadow data memory
    function automatic retire_t expected_retire(input int n);
        logic [rv32i_types::XLEN-1:0] shadow [0:1023];
        retire_t r;
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = fill_word(i * 4);
        end
        for (int k = 0; k <= n; k++) begin
            r      = '0;
            r.pc   = rv32i_types::RESET_PC + k * 4;
            r.word = (k < PROG_WORDS) ? prog[k] : NOP_WORD;
            r.op   = rv32i_types::op_none;
            if (r.word[6:0] == rv32i_types::OPC_LOAD) begin
                r.op   = rv32i_types::op_load;
                r.addr = {20'd0, r.word[31:20]};
                r.data = shadow[r.addr[11:2]];
            end else if (r.word[6:0] == rv32i_types::OPC_STORE) begin
                r.op   = rv32i_types::op_store;
                r.addr = {20'd0, r.word[31:25], r.word[11:7]};
                shadow[r.addr[11:2]] = r.word;
            end
        end
        return r;
    endfunction

    task automatic check_word(input logic [rv32i_types::XLEN-1:0] got,
                              input logic [rv32i_types::XLEN-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_op(input rv32i_types::mem_op got, input rv32i_types::mem_op exp,
                            input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at time %0t: %s is %s, expected %s", $time, what, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at time %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic build_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            case (i % 5)
                0:       prog[i] = sw_word(12'h200 + 12'((i % 8) * 4));
                1, 3:    prog[i] = lw_word(12'h200 + 12'(((i + 3) % 8) * 4));
                default: prog[i] = addi_word(12'(i));
            endcase
            if (i >= NUM_RETIRE) begin
                prog[i] = NOP_WORD;
            end
        end
        prog[0] = addi_word(12'd1);
        prog[1] = 32'h1234_50b7; // lui
        prog[2] = lw_word(12'h040);
        prog[3] = sw_word(12'h080);
        prog[4] = lw_word(12'h080); // Reads back the store above
        prog[5] = sw_word(12'h0c4);
        prog[6] = lw_word(12'h0c4);
        prog[7] = lw_word(12'h100);
        for (int i = 0; i < PROG_WORDS; i++) begin
            resp_i.prog[i] = prog[i];
        end
        for (int i = 0; i < 1024; i++) begin
            resp_i.data[i] = fill_word(i * 4);
        end
    endtask

    task automatic wait_for_retirements();
        int idle;
        int seen;
        idle = 0;
        seen = retired;
        while (retired < NUM_RETIRE && idle < MAX_GAP) begin
            @(posedge clk);
            if (retired != seen) begin
                seen = retired;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (retired < NUM_RETIRE) begin
            timeouts++;
            $display("Timeout: only %0d of %0d instructions retired", retired, NUM_RETIRE);
        end
    endtask

    // Compare process on the falling edge
    always @(negedge clk) begin
        if (retire_valid === 1'b1) begin
            exp_r = expected_retire(retired);
            check_word(retire_pc, exp_r.pc, $sformatf("retire_pc of instr %0d", retired));
            check_op(retire_op, exp_r.op, $sformatf("retire_op of instr %0d", retired));
            check_word(retire_data, exp_r.data, $sformatf("retire_data of instr %0d", retired));
            retired++;
            if (retired == NUM_RETIRE) begin
                stall_seen  = stall_cycles;
                cycles_seen = cycles;
            end
        end
        if (dmem_req === 1'b1 && !dmem_seen) begin
            exp_r     = expected_retire(retired); // Request belongs to the next retirement
            dmem_seen = 1'b1;
            if (exp_r.op == rv32i_types::op_none) begin
                errors++;
                $display("Data request at time %0t for pc %h, which is no load or store",
                         $time, exp_r.pc);
            end else begin
                check_bit(dmem_we, exp_r.op == rv32i_types::op_store, "dmem_we");
                check_word(dmem_addr, exp_r.addr, "dmem_addr");
                if (exp_r.op == rv32i_types::op_store) begin
                    check_word(dmem_wdata, exp_r.word, "dmem_wdata");
                end
            end
        end else if (dmem_req !== 1'b1) begin
            dmem_seen = 1'b0;
        end
        if (imem_req === 1'b1 && !imem_seen) begin
            imem_seen = 1'b1; // Fetches run in order with no branches
            check_word(imem_addr, rv32i_types::RESET_PC + fetched * 4,
                       $sformatf("imem_addr of fetch %0d", fetched));
            fetched++;
        end else if (imem_req !== 1'b1) begin
            imem_seen = 1'b0;
        end
    end

    initial begin
        rst = 1'b1;
        build_program();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait_for_retirements();
        if (timeouts == 0) begin
            check_word(stall_seen, cycles_seen - NUM_RETIRE, "stall_cycles");
        end
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- sim/mem_responder.sv
// Memory model for the instruction and data ports, with random response delays
module mem_responder (
    input  logic                          clk,
    input  logic                          imem_req,
    input  logic [rv32i_types::XLEN-1:0]  imem_addr,
    output logic [rv32i_types::XLEN-1:0]  imem_rdata,
    output logic                          imem_resp,
    input  logic                          dmem_req,
    input  logic                          dmem_we,
    input  logic [rv32i_types::XLEN-1:0]  dmem_addr,
    input  logic [rv32i_types::XLEN-1:0]  dmem_wdata,
    output logic [rv32i_types::XLEN-1:0]  dmem_rdata,
    output logic                          dmem_resp
);

    localparam int          PROG_WORDS = 64;
    localparam logic [31:0] NOP_WORD   = 32'h0000_0013;

    logic [rv32i_types::XLEN-1:0] prog [0:PROG_WORDS-1]; // Loaded by the testbench
    logic [rv32i_types::XLEN-1:0] data [0:1023];
    logic [31:0] lfsr;
    logic        imem_busy;
    logic        dmem_busy;
    logic [1:0]  imem_left;
    logic [1:0]  dmem_left;
    logic        imem_fire;
    logic        dmem_fire;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_delay(output logic [1:0] d);
        d[0] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        d[1] = lfsr[0];
        lfsr = lfsr_step(lfsr);
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] a);
        logic [31:0] idx;
        idx = (a - rv32i_types::RESET_PC) >> 2;
        if (a >= rv32i_types::RESET_PC && idx < PROG_WORDS) begin
            return prog[idx];
        end
        return NOP_WORD; // Outside the image
    endfunction

    // Ends a response pulse or counts down a drawn delay on one port
    task automatic count_down(input logic req, inout logic busy, inout logic [1:0] left,
                              inout logic resp, output logic fire);
        fire = 1'b0;
        if (resp) begin
            resp = 1'b0;
        end else if (req === 1'b1) begin
            if (busy) begin
                left = left - 2'd1;
            end else begin
                draw_delay(left);
                busy = 1'b1;
            end
            if (left == 2'd0) begin
                fire = 1'b1;
                busy = 1'b0;
            end
        end
    endtask

    initial begin
        lfsr       = 32'h92b4_b3a1;
        imem_resp  = 1'b0;
        dmem_resp  = 1'b0;
        imem_rdata = '0;
        dmem_rdata = '0;
        imem_busy  = 1'b0;
        dmem_busy  = 1'b0;
        imem_left  = 2'd0;
        dmem_left  = 2'd0;
    end

    always @(negedge clk) begin
        count_down(imem_req, imem_busy, imem_left, imem_resp, imem_fire);
        if (imem_fire) begin
            imem_rdata = fetch_word(imem_addr);
            imem_resp  = 1'b1;
        end
        count_down(dmem_req, dmem_busy, dmem_left, dmem_resp, dmem_fire);
        if (dmem_fire) begin
            if (dmem_we) begin
                data[dmem_addr[11:2]] = dmem_wdata;
                dmem_rdata            = '0;
            end else begin
                dmem_rdata = data[dmem_addr[11:2]];
            end
            dmem_resp = 1'b1;
        end
    end

endmodule

//--- rtl/mem_stall_top.sv
// Memory-stall front end: fetch, memory stage, stall FSM and stall counter
module mem_stall_top (
    input  logic                                 clk,
    input  logic                                 rst,
    output logic                                 imem_req,
    output logic [rv32i_types::XLEN-1:0]         imem_addr,
    input  logic [rv32i_types::XLEN-1:0]         imem_rdata,
    input  logic                                 imem_resp,
    output logic                                 dmem_req,
    output logic                                 dmem_we,
    output logic [rv32i_types::XLEN-1:0]         dmem_addr,
    output logic [rv32i_types::XLEN-1:0]         dmem_wdata,
    input  logic [rv32i_types::XLEN-1:0]         dmem_rdata,
    input  logic                                 dmem_resp,
    output logic                                 retire_valid,
    output logic [rv32i_types::XLEN-1:0]         retire_pc,
    output rv32i_types::mem_op                   retire_op,
    output logic [rv32i_types::XLEN-1:0]         retire_data,
    output logic [rv32i_types::STALL_CNT_W-1:0]  stall_cycles
);

    logic [rv32i_types::XLEN-1:0] instr;
    logic [rv32i_types::XLEN-1:0] instr_pc;
    logic                         instr_valid;

    stall_if st ();

    assign st.imem_resp = imem_resp;
    assign st.dmem_resp = dmem_resp;
    assign imem_req     = st.imem_req;
    assign dmem_req     = st.dmem_req;

    stall_fsm fsm_i (
        .clk (clk),
        .rst (rst),
        .st  (st.fsm)
    );

    stall_counter counter_i (
        .clk          (clk),
        .rst          (rst),
        .st           (st.count),
        .stall_cycles (stall_cycles)
    );

    fetch_unit fetch_i (
        .clk         (clk),
        .rst         (rst),
        .st          (st.fetch),
        .imem_addr   (imem_addr),
        .imem_rdata  (imem_rdata),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_valid (instr_valid)
    );

    mem_stage mem_i (
        .clk          (clk),
        .rst          (rst),
        .st           (st.mem),
        .instr        (instr),
        .instr_pc     (instr_pc),
        .instr_valid  (instr_valid),
        .dmem_addr    (dmem_addr),
        .dmem_we      (dmem_we),
        .dmem_wdata   (dmem_wdata),
        .dmem_rdata   (dmem_rdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_op    (retire_op),
        .retire_data  (retire_data)
    );

endmodule

//--- rtl/mem_stage.sv
// Memory stage: load/store decode, data-memory request and retire register
module mem_stage (
    input  logic                          clk,
    input  logic                          rst,
    stall_if.mem                          st,
    input  logic [rv32i_types::XLEN-1:0]  instr,
    input  logic [rv32i_types::XLEN-1:0]  instr_pc,
    input  logic                          instr_valid,
    output logic [rv32i_types::XLEN-1:0]  dmem_addr,
    output logic                          dmem_we,
    output logic [rv32i_types::XLEN-1:0]  dmem_wdata,
    input  logic [rv32i_types::XLEN-1:0]  dmem_rdata,
    output logic                          retire_valid,
    output logic [rv32i_types::XLEN-1:0]  retire_pc,
    output rv32i_types::mem_op            retire_op,
    output logic [rv32i_types::XLEN-1:0]  retire_data
);

    logic                         accept;
    rv32i_types::mem_op           op;
    logic [rv32i_types::XLEN-1:0] addr;

    assign accept = st.move && instr_valid;

    always_comb begin
        op   = rv32i_types::op_none;
        addr = {20'd0, instr[31:20]}; // I-type immediate
        if (instr[6:0] == rv32i_types::OPC_LOAD) begin
            op = rv32i_types::op_load;
        end else if (instr[6:0] == rv32i_types::OPC_STORE) begin
            op   = rv32i_types::op_store;
            addr = {20'd0, instr[31:25], instr[11:7]}; // S-type immediate
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st.dmem_req  <= 1'b0;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= 1'b0;
            if (accept && op != rv32i_types::op_none) begin
                st.dmem_req <= 1'b1;
            end else if (accept) begin
                retire_valid <= 1'b1;
            end else if (st.dmem_req && st.dmem_resp) begin
                st.dmem_req  <= 1'b0;
                retire_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dmem_addr   <= addr;
            dmem_we     <= (op == rv32i_types::op_store);
            dmem_wdata  <= instr; // Store writes its own word
            retire_pc   <= instr_pc;
            retire_op   <= op;
            retire_data <= '0;
        end else if (st.dmem_req && st.dmem_resp) begin
            retire_data <= (retire_op == rv32i_types::op_load) ? dmem_rdata : '0;
        end
    end

endmodule

//--- rtl/fetch_unit.sv
// Fetch unit: program counter, instruction request and fetched-word buffer
module fetch_unit (
    input  logic                          clk,
    input  logic                          rst,
    stall_if.fetch                        st,
    output logic [rv32i_types::XLEN-1:0]  imem_addr,
    input  logic [rv32i_types::XLEN-1:0]  imem_rdata,
    output logic [rv32i_types::XLEN-1:0]  instr,
    output logic [rv32i_types::XLEN-1:0]  instr_pc,
    output logic                          instr_valid
);

    logic [rv32i_types::XLEN-1:0] pc;
    logic [rv32i_types::XLEN-1:0] ibuf;
    logic                         ibuf_valid;

    // Last fetched word
    always_ff @(posedge clk) begin
        if (st.imem_req && st.imem_resp) begin
            ibuf <= imem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= rv32i_types::RESET_PC;
            st.imem_req <= 1'b1; // First fetch right after reset
            ibuf_valid  <= 1'b0;
        end else begin
            if (st.imem_req && st.imem_resp) begin
                st.imem_req <= 1'b0;
                ibuf_valid  <= 1'b1;
            end
            if (st.move) begin
                ibuf_valid <= 1'b0; // Word handed to the memory stage
                if (!st.stop_fetch) begin
                    pc          <= pc + 32'd4;
                    st.imem_req <= 1'b1;
                end
            end
        end
    end

    assign imem_addr   = pc;
    assign instr       = ibuf;
    assign instr_pc    = pc;
    assign instr_valid = ibuf_valid;

endmodule

//--- rtl/stall_counter.sv
// Stall counter: counts the cycles since reset in which the pipeline held
module stall_counter (
    input  logic                                 clk,
    input  logic                                 rst,
    stall_if.count                               st,
    output logic [rv32i_types::STALL_CNT_W-1:0]  stall_cycles
);

    logic [rv32i_types::STALL_CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (!st.move) begin
            count <= count + 1'b1;
        end
    end

    assign stall_cycles = count;

endmodule

//--- rtl/stall_fsm.sv
// Stall FSM: decides move and stop_fetch from the outstanding memory requests
module stall_fsm (
    input  logic   clk,
    input  logic   rst,
    stall_if.fsm   st
);

    rv32i_types::stall_state prev_state;
    rv32i_types::stall_state curr_state;
    rv32i_types::stall_state next_state;

    logic imem_open; // Request still waiting after this cycle
    logic dmem_open;

    assign imem_open = st.imem_req && !st.imem_resp;
    assign dmem_open = st.dmem_req && !st.dmem_resp;

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_state <= rv32i_types::moving;
            curr_state <= rv32i_types::wait_imem;
        end else begin
            prev_state <= curr_state;
            curr_state <= next_state;
        end
    end

    always_comb begin
        next_state = curr_state;
        case (curr_state)
            rv32i_types::moving: begin
                next_state = rv32i_types::wait_imem; // A new fetch follows every move
            end
            rv32i_types::wait_imem,
            rv32i_types::wait_dmem,
            rv32i_types::imem_dmem: begin
                if (imem_open && dmem_open) begin
                    next_state = rv32i_types::imem_dmem;
                end else if (imem_open) begin
                    next_state = rv32i_types::wait_imem;
                end else if (dmem_open) begin
                    next_state = rv32i_types::wait_dmem;
                end else begin
                    next_state = rv32i_types::moving;
                end
            end
            default: begin
                next_state = rv32i_types::wait_imem;
            end
        endcase
    end

    // Instruction wait just ended while the data access is still running
    assign st.stop_fetch = (curr_state == rv32i_types::wait_dmem) &&
                           ((prev_state == rv32i_types::wait_imem) ||
                            (prev_state == rv32i_types::imem_dmem));

    assign st.move = (curr_state == rv32i_types::moving);

endmodule

//--- rtl/stall_if.sv
// Stall bundle: memory request and response levels with move and stop_fetch
interface stall_if;

    logic imem_req;
    logic imem_resp;
    logic dmem_req;
    logic dmem_resp;
    logic move;
    logic stop_fetch;

    modport fsm (
        input  imem_req, imem_resp, dmem_req, dmem_resp,
        output move, stop_fetch
    );

    modport fetch (
        input  imem_resp, move, stop_fetch,
        output imem_req
    );

    modport mem (
        input  dmem_resp, move,
        output dmem_req
    );

    modport count (
        input  move
    );

endinterface

//--- rtl/rv32i_types.sv
// RV32I types: stall states, memory operation kinds and core constants
package rv32i_types;

    localparam int XLEN        = 32;
    localparam int STALL_CNT_W = 32;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0100;

    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // Pipeline stall condition
    typedef enum logic [1:0] {
        moving,
        wait_imem,
        wait_dmem,
        imem_dmem
    } stall_state;

    // Memory operation kind of a retired word
    typedef enum logic [1:0] {
        op_none,
        op_load,
        op_store
    } mem_op;

endpackage
